// File: hw/csr_pkg.sv
// Shared types and constants for the machine-mode CSR block.
// Holds the CSR address map, trap cause codes, field positions,
// reset values and the packed structs passed between the blocks.
// Every RTL file of the block imports this package.

package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [11:0]     csr_addr_t;
    typedef logic [XLEN-1:0] xlen_t;

    // ------------------------------
    // machine CSR addresses
    // ------------------------------
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // ------------------------------
    // trap cause codes
    // ------------------------------
    // interrupt causes carry the top bit
    localparam xlen_t INTR_BIT  = {1'b1, {(XLEN-1){1'b0}}};
    localparam xlen_t CAUSE_MSI = INTR_BIT | xlen_t'(3);
    localparam xlen_t CAUSE_MTI = INTR_BIT | xlen_t'(7);
    localparam xlen_t CAUSE_MEI = INTR_BIT | xlen_t'(11);

    localparam xlen_t CAUSE_INS_MISALIGNED   = xlen_t'(0);
    localparam xlen_t CAUSE_INS_FAULT        = xlen_t'(1);
    localparam xlen_t CAUSE_ILLEGAL          = xlen_t'(2);
    localparam xlen_t CAUSE_LOAD_MISALIGNED  = xlen_t'(4);
    localparam xlen_t CAUSE_STORE_MISALIGNED = xlen_t'(6);
    localparam xlen_t CAUSE_ECALL_M          = xlen_t'(11);

    // ------------------------------
    // field positions, masks and reset values
    // ------------------------------
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;
    localparam int IRQ_MSI        = 3;
    localparam int IRQ_MTI        = 7;
    localparam int IRQ_MEI        = 11;

    // previous mode always reads as machine
    localparam logic [1:0] MSTATUS_MPP_M = 2'b11;
    // mode field values 2 and 3 are reserved, so bit 1 never sticks
    localparam xlen_t MTVEC_WR_MASK = ~xlen_t'(2);
    localparam logic [1:0] EPC_LOB  = 2'b00;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_lines_t;

    typedef struct packed {
        logic ferr;
        logic uerr;
        logic maif;
        logic mala;
        logic masa;
        logic ilgl;
        logic ecall;
    } excp_flags_t;

    typedef struct packed {
        logic             mstatus_mie;
        logic             mstatus_mpie;
        irq_lines_t       mie_en;
        logic [XLEN-3:0]  mtvec_base;
        logic             mtvec_vec;
        xlen_t            mscratch;
        logic [XLEN-3:0]  mepc;
        xlen_t            mcause;
        xlen_t            mtval;
    } csr_state_t;

    typedef struct packed {
        xlen_t cause;
        xlen_t value;
    } trap_info_t;

    // place the three irq bits at their mie/mip positions
    function automatic xlen_t irq_word(irq_lines_t v);
        xlen_t w;
        w          = '0;
        w[IRQ_MSI] = v.msip;
        w[IRQ_MTI] = v.mtip;
        w[IRQ_MEI] = v.meip;
        return w;
    endfunction

endpackage

// File: hw/irq_ctrl.sv
// Machine interrupt masking and cause encoding.
// Raw lines are masked by the mie enables and the global MIE bit;
// the highest priority enabled line gives the interrupt cause.

`timescale 1ns/10ps

module irq_ctrl import csr_pkg::*; (
    input  irq_lines_t irq_i,
    input  csr_state_t state_i,
    output irq_lines_t pending_o,
    output logic       interrupt_o,
    output xlen_t      irq_cause_o
);

    irq_lines_t enabled;

    // mip shows the raw lines, unmasked
    assign pending_o = irq_i;

    assign enabled     = irq_i & state_i.mie_en & {3{state_i.mstatus_mie}};
    assign interrupt_o = |enabled;

    // ------------------------------
    // cause priority encoder
    // ------------------------------
    // external first, then software, then timer
    always_comb begin
        if (enabled.meip) begin
            irq_cause_o = CAUSE_MEI;
        end else if (enabled.msip) begin
            irq_cause_o = CAUSE_MSI;
        end else begin
            // timer, or don't care when nothing is pending
            irq_cause_o = CAUSE_MTI;
        end
    end

endmodule

// File: hw/excp_encoder.sv
// Synchronous exception cause encoder and trap value select.
// Picks one cause from the exception flags by fixed priority and
// chooses the value that goes into mtval on trap entry.

`timescale 1ns/10ps

module excp_encoder import csr_pkg::*; (
    input  excp_flags_t excp_i,
    input  logic        interrupt_i,
    input  xlen_t       excp_pc_i,
    input  xlen_t       excp_ins_i,
    output xlen_t       excp_cause_o,
    output xlen_t       trap_value_o
);

    logic misaligned;
    logic illegal;

    assign misaligned = excp_i.maif | excp_i.mala | excp_i.masa;
    assign illegal    = excp_i.uerr | excp_i.ilgl;

    // ------------------------------
    // cause encoder
    // ------------------------------
    // order matters here
    always_comb begin
        if (excp_i.ferr) begin
            excp_cause_o = CAUSE_INS_FAULT;
        end else if (illegal) begin
            excp_cause_o = CAUSE_ILLEGAL;
        end else if (excp_i.maif) begin
            excp_cause_o = CAUSE_INS_MISALIGNED;
        end else if (excp_i.mala) begin
            excp_cause_o = CAUSE_LOAD_MISALIGNED;
        end else if (excp_i.masa) begin
            excp_cause_o = CAUSE_STORE_MISALIGNED;
        end else begin
            // only reached for ecall with no other fault
            excp_cause_o = CAUSE_ECALL_M;
        end
    end

    // ------------------------------
    // trap value select
    // ------------------------------
    always_comb begin
        if (interrupt_i) begin
            trap_value_o = '0;
        end else if (misaligned) begin
            trap_value_o = excp_pc_i;
        end else if (illegal) begin
            trap_value_o = excp_ins_i;
        end else begin
            trap_value_o = '0;
        end
    end

endmodule

// File: hw/trap_vector.sv
// Trap decision and trap entry address.
// A trap is taken when the stage is valid and either an interrupt
// is enabled or any exception flag is set. Interrupts win over
// exceptions for the cause. The entry address is the mtvec base,
// offset by four times the cause code for vectored interrupts.

`timescale 1ns/10ps

module trap_vector import csr_pkg::*; (
    input  logic        ex_valid_i,
    input  excp_flags_t excp_i,
    input  logic        interrupt_i,
    input  xlen_t       irq_cause_i,
    input  xlen_t       excp_cause_i,
    input  xlen_t       trap_value_i,
    input  csr_state_t  state_i,
    output logic        trap_take_o,
    output trap_info_t  trap_o,
    output xlen_t       entry_addr_o
);

    xlen_t            trap_cause;
    logic [XLEN-3:0]  vec_base;

    assign trap_take_o = ex_valid_i & (interrupt_i | (|excp_i));

    // ------------------------------
    // cause select
    // ------------------------------
    always_comb begin
        if (interrupt_i) begin
            trap_cause = irq_cause_i;
        end else begin
            trap_cause = excp_cause_i;
        end
    end

    assign trap_o.cause = trap_cause;
    assign trap_o.value = trap_value_i;

    // ------------------------------
    // entry address
    // ------------------------------
    // word offset is the cause code without the interrupt bit
    assign vec_base = state_i.mtvec_base + irq_cause_i[XLEN-3:0];

    always_comb begin
        if (interrupt_i && state_i.mtvec_vec) begin
            entry_addr_o = {vec_base, 2'b00};
        end else begin
            entry_addr_o = {state_i.mtvec_base, 2'b00};
        end
    end

endmodule

// File: hw/csr_regs.sv
// Machine CSR state registers.
// Applies trap entry, mret and CSR writes on enabled clock edges,
// in that priority order. Nothing changes while exs_en_i is low.
// The full state leaves as one packed struct.

`timescale 1ns/10ps

module csr_regs import csr_pkg::*; #(
    parameter xlen_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       exs_en_i,
    input  logic       trap_take_i,
    input  trap_info_t trap_i,
    input  xlen_t      excp_pc_i,
    input  logic       trap_rtn_i,
    input  logic       wr_i,
    input  csr_addr_t  wr_addr_i,
    input  xlen_t      wr_data_i,
    output csr_state_t state_o
);

    csr_state_t state_q;
    xlen_t      mtvec_wr;

    assign mtvec_wr = wr_data_i & MTVEC_WR_MASK;

    // ------------------------------
    // state update
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q.mstatus_mie  <= 1'b0;
            state_q.mstatus_mpie <= 1'b0;
            state_q.mie_en       <= '0;
            // direct mode out of reset
            state_q.mtvec_base   <= RESET_VECTOR[XLEN-1:2];
            state_q.mtvec_vec    <= 1'b0;
        end else if (exs_en_i) begin
            if (trap_take_i) begin
                // trap entry overrides mret and any write
                state_q.mstatus_mpie <= state_q.mstatus_mie;
                state_q.mstatus_mie  <= 1'b0;
                state_q.mepc         <= excp_pc_i[XLEN-1:2];
                state_q.mcause       <= trap_i.cause;
                state_q.mtval        <= trap_i.value;
            end else if (trap_rtn_i) begin
                // mret
                state_q.mstatus_mie  <= state_q.mstatus_mpie;
                state_q.mstatus_mpie <= 1'b1;
            end else if (wr_i) begin
                case (wr_addr_i)
                    CSR_MSTATUS: begin
                        state_q.mstatus_mie  <= wr_data_i[MSTATUS_MIE];
                        state_q.mstatus_mpie <= wr_data_i[MSTATUS_MPIE];
                    end
                    CSR_MIE: begin
                        state_q.mie_en.meip <= wr_data_i[IRQ_MEI];
                        state_q.mie_en.mtip <= wr_data_i[IRQ_MTI];
                        state_q.mie_en.msip <= wr_data_i[IRQ_MSI];
                    end
                    CSR_MTVEC: begin
                        state_q.mtvec_base <= mtvec_wr[XLEN-1:2];
                        state_q.mtvec_vec  <= mtvec_wr[0];
                    end
                    CSR_MSCRATCH: begin
                        state_q.mscratch <= wr_data_i;
                    end
                    CSR_MEPC: begin
                        state_q.mepc <= wr_data_i[XLEN-1:2];
                    end
                    CSR_MCAUSE: begin
                        state_q.mcause <= wr_data_i;
                    end
                    CSR_MTVAL: begin
                        state_q.mtval <= wr_data_i;
                    end
                    default: begin
                        // mip, misa, ID registers and unknown
                        // addresses drop the write
                    end
                endcase
            end
        end
    end

    assign state_o = state_q;

endmodule

// File: hw/csr_read.sv
// CSR read port.
// Decodes the address into read data and flags, and registers all
// three on access_i while the stage is enabled. Outputs hold until
// the next access and are cleared by reset.

`timescale 1ns/10ps

module csr_read import csr_pkg::*; #(
    parameter xlen_t HART_ID = 32'h0000_0000
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       exs_en_i,
    input  logic       access_i,
    input  csr_addr_t  addr_i,
    input  csr_state_t state_i,
    input  irq_lines_t pending_i,
    output xlen_t      rd_data_o,
    output logic       bad_csr_addr_o,
    output logic       readonly_csr_o
);

    xlen_t rd_data;
    logic  rd_invalid;
    logic  rd_readonly;

    // ------------------------------
    // read decode
    // ------------------------------
    always_comb begin
        rd_data    = '0;
        rd_invalid = 1'b0;
        case (addr_i)
            CSR_MSTATUS: begin
                rd_data[MSTATUS_MIE]                   = state_i.mstatus_mie;
                rd_data[MSTATUS_MPIE]                  = state_i.mstatus_mpie;
                rd_data[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = MSTATUS_MPP_M;
            end
            CSR_MIE:       rd_data = irq_word(state_i.mie_en);
            CSR_MTVEC:     rd_data = {state_i.mtvec_base, 1'b0, state_i.mtvec_vec};
            CSR_MSCRATCH:  rd_data = state_i.mscratch;
            CSR_MEPC:      rd_data = {state_i.mepc, EPC_LOB};
            CSR_MCAUSE:    rd_data = state_i.mcause;
            CSR_MTVAL:     rd_data = state_i.mtval;
            CSR_MIP:       rd_data = irq_word(pending_i);
            CSR_MHARTID:   rd_data = HART_ID;
            // implemented but read as zero
            CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID: begin
                rd_data = '0;
            end
            default: begin
                rd_invalid = 1'b1;
            end
        endcase
    end

    // top two address bits set means read-only space
    assign rd_readonly = &addr_i[11:10];

    // ------------------------------
    // output registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_data_o      <= '0;
            bad_csr_addr_o <= 1'b0;
            readonly_csr_o <= 1'b0;
        end else if (exs_en_i && access_i) begin
            rd_data_o      <= rd_data;
            bad_csr_addr_o <= rd_invalid;
            readonly_csr_o <= rd_readonly;
        end
    end

endmodule

// File: hw/csr_file.sv
// Top level of the machine-mode CSR block.
// Connects the register state, read port, interrupt control,
// exception encoder and trap vector logic. RESET_VECTOR sets the
// reset mtvec base and HART_ID the value read from mhartid.

`timescale 1ns/10ps

module csr_file import csr_pkg::*; #(
    parameter xlen_t RESET_VECTOR = 32'h0000_0000,
    parameter xlen_t HART_ID      = 32'h0000_0000
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        exs_en_i,
    // read port
    input  logic        access_i,
    input  csr_addr_t   addr_i,
    output xlen_t       rd_data_o,
    output logic        bad_csr_addr_o,
    output logic        readonly_csr_o,
    // write port
    input  logic        wr_i,
    input  csr_addr_t   wr_addr_i,
    input  xlen_t       wr_data_i,
    // trap interface
    input  logic        ex_valid_i,
    input  irq_lines_t  irq_i,
    input  excp_flags_t excp_i,
    input  xlen_t       excp_pc_i,
    input  xlen_t       excp_ins_i,
    input  logic        trap_rtn_i,
    output logic        interrupt_o,
    output logic        jump_to_trap_o,
    output xlen_t       trap_entry_addr_o,
    output xlen_t       trap_rtn_addr_o,
    output xlen_t       trap_cause_o
);

    csr_state_t state;
    irq_lines_t pending;
    xlen_t      irq_cause;
    xlen_t      excp_cause;
    xlen_t      trap_value;
    logic       trap_take;
    trap_info_t trap;

    assign jump_to_trap_o  = trap_take;
    assign trap_cause_o    = trap.cause;
    assign trap_rtn_addr_o = {state.mepc, EPC_LOB};

    csr_regs #(
        .RESET_VECTOR(RESET_VECTOR)
    ) csr_regs_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .exs_en_i   (exs_en_i),
        .trap_take_i(trap_take),
        .trap_i     (trap),
        .excp_pc_i  (excp_pc_i),
        .trap_rtn_i (trap_rtn_i),
        .wr_i       (wr_i),
        .wr_addr_i  (wr_addr_i),
        .wr_data_i  (wr_data_i),
        .state_o    (state)
    );

    csr_read #(
        .HART_ID(HART_ID)
    ) csr_read_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .exs_en_i      (exs_en_i),
        .access_i      (access_i),
        .addr_i        (addr_i),
        .state_i       (state),
        .pending_i     (pending),
        .rd_data_o     (rd_data_o),
        .bad_csr_addr_o(bad_csr_addr_o),
        .readonly_csr_o(readonly_csr_o)
    );

    irq_ctrl irq_ctrl_inst (
        .irq_i      (irq_i),
        .state_i    (state),
        .pending_o  (pending),
        .interrupt_o(interrupt_o),
        .irq_cause_o(irq_cause)
    );

    excp_encoder excp_encoder_inst (
        .excp_i      (excp_i),
        .interrupt_i (interrupt_o),
        .excp_pc_i   (excp_pc_i),
        .excp_ins_i  (excp_ins_i),
        .excp_cause_o(excp_cause),
        .trap_value_o(trap_value)
    );

    trap_vector trap_vector_inst (
        .ex_valid_i  (ex_valid_i),
        .excp_i      (excp_i),
        .interrupt_i (interrupt_o),
        .irq_cause_i (irq_cause),
        .excp_cause_i(excp_cause),
        .trap_value_i(trap_value),
        .state_i     (state),
        .trap_take_o (trap_take),
        .trap_o      (trap),
        .entry_addr_o(trap_entry_addr_o)
    );

endmodule

// File: bench/csr_file_checker.sv
// Assertions on the CSR block outputs, bound into every csr_file.
// Covers trap jumps against the valid strobe, the read flags after
// reset and the word alignment of the trap entry address.

`timescale 1ns/10ps

module csr_file_checker import csr_pkg::*; (
    input logic  clk_i,
    input logic  reset_i,
    input logic  ex_valid_i,
    input logic  jump_i,
    input logic  bad_addr_i,
    input logic  readonly_i,
    input xlen_t entry_addr_i
);

    // number of failed assertions so far
    int failures = 0;

    // a trap is only taken from a valid stage
    jump_needs_valid: assert property (
        @(posedge clk_i) disable iff (reset_i)
        jump_i |-> ex_valid_i
    ) else begin
        $error("jump_to_trap_o high without ex_valid_i");
        failures++;
    end

    // read flags come out of reset cleared
    flags_clear_after_reset: assert property (
        @(posedge clk_i)
        reset_i |=> (!bad_addr_i && !readonly_i)
    ) else begin
        $error("read flags set in the cycle after reset");
        failures++;
    end

    entry_word_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        entry_addr_i[1:0] == 2'b00
    ) else begin
        $error("trap_entry_addr_o not word aligned");
        failures++;
    end

endmodule

bind csr_file csr_file_checker csr_file_checker_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ex_valid_i  (ex_valid_i),
    .jump_i      (jump_to_trap_o),
    .bad_addr_i  (bad_csr_addr_o),
    .readonly_i  (readonly_csr_o),
    .entry_addr_i(trap_entry_addr_o)
);

// File: bench/tb_csr_file.sv
// Testbench for the machine-mode CSR block.
// Reads operation records from bench/csr_patterns.txt, drives each one
// into the DUT and compares reads, trap outputs and return addresses
// with the expected values held in the record.

`timescale 1ns/10ps

module tb_csr_file import csr_pkg::*; ();

    localparam string PATTERN_FILE = "bench/csr_patterns.txt";
    localparam int    WAIT_LIMIT   = 3;

    logic clk_i, reset_i, exs_en_i, access_i, wr_i, ex_valid_i, trap_rtn_i;
    csr_addr_t addr_i, wr_addr_i;
    xlen_t wr_data_i, excp_pc_i, excp_ins_i;
    irq_lines_t irq_i;
    excp_flags_t excp_i;
    xlen_t rd_data_o, trap_entry_addr_o, trap_rtn_addr_o, trap_cause_o;
    logic bad_csr_addr_o, readonly_csr_o, interrupt_o, jump_to_trap_o;

    int errors, checks, test_errs, test_checks, tests_ok, tests_bad, cur_test;
    bit aborted;

    csr_file #(
        .RESET_VECTOR(32'h0000_0100),
        .HART_ID     (32'h0000_0000)
    ) csr_file_inst (.*);

    always #4 clk_i = ~clk_i;

    task automatic clear_inputs();
        exs_en_i   = 1'b1;
        access_i   = 1'b0;
        addr_i     = '0;
        wr_i       = 1'b0;
        wr_addr_i  = '0;
        wr_data_i  = '0;
        ex_valid_i = 1'b0;
        irq_i      = '0;
        excp_i     = '0;
        excp_pc_i  = '0;
        excp_ins_i = '0;
        trap_rtn_i = 1'b0;
    endtask

    task automatic compare(input xlen_t got, input xlen_t expected, input string what);
        checks++;
        test_checks++;
        if (got !== expected) begin
            $display("[FAIL] %0d ns: test %0d %s is %h, expected %h",
                     $time, cur_test, what, got, expected);
            errors++;
            test_errs++;
        end
    endtask

    task automatic end_test();
        if (cur_test != 0) begin
            if (test_errs == 0) begin
                tests_ok++;
                $display("test %0d done: %0d checks ok", cur_test, test_checks);
            end else begin
                tests_bad++;
                $display("test %0d done: %0d of %0d checks wrong",
                         cur_test, test_errs, test_checks);
            end
        end
        test_errs   = 0;
        test_checks = 0;
    endtask

    // ------------------------------
    // operations, each starts and ends 1 ns after a rising edge
    // ------------------------------
    task automatic read_csr(input csr_addr_t addr, input xlen_t exp_data,
                            input xlen_t exp_flags);
        access_i = 1'b1;
        addr_i   = addr;
        @(posedge clk_i);
        #1 access_i = 1'b0;
        @(negedge clk_i);
        compare(rd_data_o, exp_data, "read data");
        compare(xlen_t'({interrupt_o, bad_csr_addr_o, readonly_csr_o}), exp_flags,
                "interrupt/bad/readonly flags");
        @(posedge clk_i);
        #1;
    endtask

    task automatic write_csr(input csr_addr_t addr, input xlen_t data);
        wr_i      = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        @(posedge clk_i);
        #1 wr_i = 1'b0;
    endtask

    task automatic check_trap(input xlen_t pc, input xlen_t ins, input xlen_t flags,
                              input xlen_t exp_cause, input xlen_t exp_entry,
                              input logic is_irq);
        int waited;
        ex_valid_i = 1'b1;
        excp_pc_i  = pc;
        excp_ins_i = ins;
        if (is_irq) begin
            irq_i = irq_lines_t'(flags[2:0]);
        end else begin
            excp_i = excp_flags_t'(flags[6:0]);
        end
        @(negedge clk_i);
        waited = 0;
        // stays well before the next rising edge
        while (!jump_to_trap_o && waited < WAIT_LIMIT) begin
            #1 waited++;
        end
        if (!jump_to_trap_o) begin
            $display("timeout: jump_to_trap_o did not rise in test %0d", cur_test);
            aborted = 1'b1;
        end else begin
            compare(xlen_t'(interrupt_o), xlen_t'(is_irq), "interrupt_o");
            compare(trap_cause_o, exp_cause, "trap cause");
            compare(trap_entry_addr_o, exp_entry, "trap entry address");
        end
        @(posedge clk_i);
        #1;
        ex_valid_i = 1'b0;
        irq_i      = '0;
        excp_i     = '0;
    endtask

    task automatic check_mret(input xlen_t exp_addr);
        trap_rtn_i = 1'b1;
        @(negedge clk_i);
        compare(trap_rtn_addr_o, exp_addr, "return address");
        @(posedge clk_i);
        #1 trap_rtn_i = 1'b0;
    endtask

    task automatic run_patterns(input int fd);
        string      line;
        logic [7:0] op;
        int         test;
        int         n;
        xlen_t      a, d, f, x1, x2;
        bit         finished;
        finished = 1'b0;
        while (!finished && !aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %h %h %h %h %h", op, test, a, d, f, x1, x2);
                if (n != 7) begin
                    $display("bad pattern record: %s", line);
                    aborted = 1'b1;
                end else begin
                    if (test != cur_test) begin
                        end_test();
                        cur_test = test;
                    end
                    case (op)
                        "R": read_csr(a[11:0], x1, x2);
                        "W": write_csr(a[11:0], d);
                        "E": check_trap(a, d, f, x1, x2, 1'b0);
                        "I": check_trap(a, d, f, x1, x2, 1'b1);
                        "M": check_mret(x1);
                        "Q": finished = 1'b1;
                        default: begin
                            $display("unknown operation %c in pattern file", op);
                            aborted = 1'b1;
                        end
                    endcase
                end
            end
        end
        if (!finished && !aborted) begin
            $display("pattern file ended without an end record");
            aborted = 1'b1;
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int fd;
        int assert_fails;
        clk_i   = 1'b0;
        reset_i = 1'b1;
        aborted = 1'b0;
        clear_inputs();
        repeat (2) @(posedge clk_i);
        #1 reset_i = 1'b0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            aborted = 1'b1;
        end else begin
            run_patterns(fd);
            $fclose(fd);
        end
        assert_fails = csr_file_inst.csr_file_checker_inst.failures;
        $display("tests: %0d ok, %0d failed; checks: %0d run, %0d wrong; assertions: %0d failed",
                 tests_ok, tests_bad, checks, errors, assert_fails);
        if (!aborted && errors == 0 && tests_bad == 0 && assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
hw/csr_pkg.sv
hw/irq_ctrl.sv
hw/excp_encoder.sv
hw/trap_vector.sv
hw/csr_regs.sv
hw/csr_read.sv
hw/csr_file.sv
bench/csr_file_checker.sv
bench/tb_csr_file.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_csr_file
RTL_TOP    ?= csr_file
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
RTL_SRCS   ?= hw/csr_pkg.sv hw/irq_ctrl.sv hw/excp_encoder.sv hw/trap_vector.sv \
              hw/csr_regs.sv hw/csr_read.sv hw/csr_file.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/csr_patterns.txt
# op test addr data flags exp1 exp2 (test in decimal, the rest in hex)
# R: exp1 read data, exp2 {interrupt, bad, readonly}; W: write data to addr
# E/I: addr is pc, data is instruction, flags excp or irq lines, exp1 cause, exp2 entry
# M: mret, exp1 return address; Q: end of records
R 1 300 0 0 1800 0
R 1 305 0 0 100 0
R 1 304 0 0 0 0
R 1 f14 0 0 0 1
W 2 340 a5a55a5a 0 0 0
R 2 340 0 0 a5a55a5a 0
W 2 305 203 0 0 0
R 2 305 0 0 201 0
W 2 341 107 0 0 0
R 2 341 0 0 104 0
W 2 304 ffffffff 0 0 0
R 2 304 0 0 888 0
W 2 344 ffffffff 0 0 0
R 2 344 0 0 0 0
R 3 7c0 0 0 0 2
R 3 f11 0 0 0 1
R 3 340 0 0 a5a55a5a 0
W 4 300 8 0 0 0
E 4 1006 deadbeef 50 1 200
R 4 300 0 0 1880 0
R 4 341 0 0 1004 0
R 4 342 0 0 1 0
R 4 343 0 0 1006 0
E 4 2000 12345678 20 2 200
R 4 300 0 0 1800 0
R 4 343 0 0 12345678 0
E 4 3003 0 0a 2 200
R 4 343 0 0 3003 0
E 4 4001 0 5 6 200
R 4 342 0 0 6 0
E 4 5000 0 1 b 200
R 4 343 0 0 0 0
W 5 300 8 0 0 0
I 5 6000 0 7 8000000b 22c
R 5 300 0 0 1880 0
M 5 0 0 0 6000 0
R 5 300 0 0 1888 0
I 5 7004 0 3 80000003 20c
M 5 0 0 0 7004 0
I 5 8008 0 2 80000007 21c
R 5 343 0 0 0 0
M 5 0 0 0 8008 0
Q 0 0 0 0 0 0
